//--- Makefile
# Verilator build and run for the RV32I core testbench

TOP := tb_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timescale 1ns/1ps --top-module $(TOP) \
		-f vlog.f --Mdir obj_dir -o sim_core

run: compile
	./obj_dir/sim_core | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    data;
} commit_t;

// shadow register state and expected commits
word_t   shadow [0:31];
commit_t exp_q [$];
word_t   prog [0:63];
int      prog_len;
logic    have_last;
word_t   last_pc;

function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

task automatic new_program();
    prog_len = 0;
    exp_q.delete();
    for (int i = 0; i < 32; i++) begin
        shadow[i] = '0;
    end
endtask

task automatic put_word(input word_t instr, input logic commits,
                        input reg_idx_t rd, input word_t data);
    commit_t c;
    if (commits) begin
        c.pc   = BOOT + word_t'(prog_len * 4);
        c.rd   = rd;
        c.data = data;
        exp_q.push_back(c);
        if (rd != 5'd0) begin
            shadow[rd] = data;
        end
    end
    prog[prog_len] = instr;
    prog_len++;
endtask

task automatic emit_r(input logic [2:0] f3, input logic alt, input reg_idx_t rd,
                      input reg_idx_t rs1, input reg_idx_t rs2);
    word_t instr;
    instr = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
    put_word(instr, 1'b1, rd, ref_alu(f3, alt, shadow[rs1], shadow[rs2]));
endtask

task automatic emit_i(input logic [2:0] f3, input reg_idx_t rd, input reg_idx_t rs1,
                      input logic [11:0] imm);
    word_t instr;
    instr = {imm, rs1, f3, rd, 7'b0010011};
    put_word(instr, 1'b1, rd, ref_alu(f3, 1'b0, shadow[rs1], {{20{imm[11]}}, imm}));
endtask

task automatic emit_lui(input reg_idx_t rd, input logic [19:0] imm);
    put_word({imm, rd, 7'b0110111}, 1'b1, rd, {imm, 12'b0});
endtask

task automatic emit_bad(input word_t instr);
    put_word(instr, 1'b0, 5'd0, '0);
endtask

task automatic check_word(input string name, input word_t exp, input word_t got);
    if (got !== exp) begin
        $display("Error %s exp 0x%08h got 0x%08h", name, exp, got);
        err_cnt++;
    end
endtask

task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t got);
    if (got !== exp) begin
        $display("Error %s exp 0x%02h got 0x%02h", name, exp, got);
        err_cnt++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
        $display("Error %s exp 0x%0h got 0x%0h", name, exp, got);
        err_cnt++;
    end
endtask

task automatic observe_commit(input logic check_step);
    commit_t c;
    if (commit_valid_o) begin
        if (exp_q.size() == 0) begin
            $display("Unexpected commit at pc 0x%08h, no instruction left to commit",
                     commit_pc_o);
            err_cnt++;
        end else begin
            c = exp_q.pop_front();
            check_word("commit_pc_o", c.pc, commit_pc_o);
            check_idx("commit_rd_o", c.rd, commit_rd_o);
            check_word("commit_data_o", c.data, commit_data_o);
            if (check_step && have_last) begin
                check_word("commit_pc_o step", last_pc + 32'd4, commit_pc_o);
            end
            have_last = 1'b1;
            last_pc   = c.pc;
        end
    end
endtask

task automatic run_program(input logic stalls);
    int quiet;
    stall_mode = stalls;
    fetch_en   = 1'b1;
    have_last  = 1'b0;
    quiet      = 0;
    // keep watching a few cycles after the last commit for strays
    while ((exp_q.size() != 0) || (quiet < 4)) begin
        @(negedge mem2wb_inst_selfdefine_o);
        observe_commit(stalls);
        if (exp_q.size() == 0) begin
            quiet++;
        end
    end
    fetch_en   = 1'b0;
    stall_mode = 1'b0;
endtask

task automatic boot_after_reset();
    new_program();
    emit_i(3'b000, 5'd1, 5'd0, 12'h011);
    emit_i(3'b000, 5'd2, 5'd1, 12'h022);
    emit_r(3'b000, 1'b0, 5'd3, 5'd1, 5'd2);
    apply_reset();
    // fetch held off, core idles at the boot address
    repeat (3) begin
        check_bit("fetch_valid_o", 1'b1, fetch_valid_o);
        check_word("fetch_addr_o", BOOT, fetch_addr_o);
        check_bit("commit_valid_o", 1'b0, commit_valid_o);
        @(negedge mem2wb_inst_selfdefine_o);
    end
    run_program(1'b0);
endtask

task automatic imm_and_lui();
    new_program();
    emit_lui(5'd1, 20'h12345);
    emit_i(3'b000, 5'd1, 5'd1, 12'h678);
    emit_i(3'b000, 5'd2, 5'd0, 12'hfff);
    emit_lui(5'd3, 20'hfffff);
    emit_i(3'b000, 5'd3, 5'd3, 12'h7ff);
    emit_i(3'b010, 5'd4, 5'd2, 12'h000);
    emit_i(3'b100, 5'd5, 5'd1, 12'hfff);
    emit_i(3'b110, 5'd6, 5'd0, 12'h555);
    emit_i(3'b111, 5'd7, 5'd1, 12'h0f0);
    emit_i(3'b001, 5'd8, 5'd6, 12'h004);
    emit_i(3'b101, 5'd9, 5'd2, 12'h01c);
    apply_reset();
    run_program(1'b0);
endtask

// each op reads the results of the two before it
task automatic build_dep_program();
    new_program();
    emit_i(3'b000, 5'd1, 5'd0, 12'd100);
    emit_i(3'b000, 5'd2, 5'd0, 12'hff9);
    emit_r(3'b000, 1'b0, 5'd3, 5'd1, 5'd2);
    emit_r(3'b000, 1'b1, 5'd4, 5'd3, 5'd2);
    emit_r(3'b111, 1'b0, 5'd5, 5'd4, 5'd3);
    emit_r(3'b110, 1'b0, 5'd6, 5'd5, 5'd4);
    emit_r(3'b100, 1'b0, 5'd7, 5'd6, 5'd5);
    emit_r(3'b010, 1'b0, 5'd8, 5'd2, 5'd7);
    emit_r(3'b001, 1'b0, 5'd9, 5'd7, 5'd8);
    emit_r(3'b101, 1'b0, 5'd10, 5'd2, 5'd8);
    emit_r(3'b000, 1'b0, 5'd11, 5'd10, 5'd9);
    emit_r(3'b000, 1'b1, 5'd11, 5'd11, 5'd10);
endtask

task automatic dependent_alu_ops();
    build_dep_program();
    apply_reset();
    run_program(1'b0);
endtask

task automatic fetch_backpressure();
    build_dep_program();
    apply_reset();
    run_program(1'b1);
endtask

task automatic x0_and_illegal();
    new_program();
    emit_i(3'b000, 5'd0, 5'd0, 12'd77);
    emit_bad(32'h0000_0000);
    emit_r(3'b000, 1'b0, 5'd5, 5'd0, 5'd0);
    emit_lui(5'd0, 20'habcde);
    emit_i(3'b000, 5'd6, 5'd0, 12'h003);
    // mul, srai, lw and jal
    emit_bad({7'b0000001, 5'd6, 5'd6, 3'b000, 5'd7, 7'b0110011});
    emit_bad({7'b0100000, 5'd3, 5'd6, 3'b101, 5'd7, 7'b0010011});
    emit_bad(32'h0000_2083);
    emit_bad(32'h0000_006f);
    emit_r(3'b000, 1'b0, 5'd7, 5'd6, 5'd6);
    emit_r(3'b000, 1'b1, 5'd8, 5'd0, 5'd6);
    apply_reset();
    run_program(1'b0);
endtask

`endif

//--- dv/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core import rv_core_pkg::*;;

    localparam word_t BOOT = 32'h8000_0000;

    // instruction counts of the directed tests
    localparam int T1_LEN = 3;
    localparam int T2_LEN = 11;
    localparam int T3_LEN = 12;
    localparam int T4_LEN = 12;
    localparam int T5_LEN = 11;
    localparam int TIMEOUT_LIMIT = (T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN) * 4 + 200;

    logic     mem2wb_inst_selfdefine_o = 1'b0;
    logic     reset                    = 1'b1;
    logic     fetch_ready_i            = 1'b0;
    word_t    fetch_data_i             = '0;
    logic     fetch_valid_o;
    word_t    fetch_addr_o;
    logic     commit_valid_o;
    word_t    commit_pc_o;
    reg_idx_t commit_rd_o;
    word_t    commit_data_o;

    logic   fetch_en   = 1'b0;
    logic   stall_mode = 1'b0;
    integer seed       = 45;
    int     rnd;
    int     err_cnt    = 0;
    int     cycle_cnt  = 0;

    task automatic apply_reset();
        @(posedge mem2wb_inst_selfdefine_o);
        #1;
        reset = 1'b1;
        repeat (10) @(posedge mem2wb_inst_selfdefine_o);
        #1;
        reset = 1'b0;
        @(negedge mem2wb_inst_selfdefine_o);
    endtask

    `include "tb_checks.svh"

    always #2 mem2wb_inst_selfdefine_o = ~mem2wb_inst_selfdefine_o;

    core_top #(
        .BOOT_ADDR(BOOT)
    ) dut (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset                   (reset),
        .fetch_valid_o           (fetch_valid_o),
        .fetch_addr_o            (fetch_addr_o),
        .fetch_ready_i           (fetch_ready_i),
        .fetch_data_i            (fetch_data_i),
        .commit_valid_o          (commit_valid_o),
        .commit_pc_o             (commit_pc_o),
        .commit_rd_o             (commit_rd_o),
        .commit_data_o           (commit_data_o)
    );

    // words past the program decode as opcode 7f and never commit
    function automatic word_t mem_word(input word_t addr);
        word_t off;
        word_t h;
        off = addr - BOOT;
        if ((addr >= BOOT) && ((off >> 2) < word_t'(prog_len))) begin
            return prog[off[7:2]];
        end
        h = addr * 32'h9E37_79B1;
        h = h ^ (h >> 16);
        return {h[31:7], 7'h7f};
    endfunction

    // instruction memory model
    always @(posedge mem2wb_inst_selfdefine_o) begin
        #1;
        rnd = $random(seed);
        if (!fetch_en) begin
            fetch_ready_i <= 1'b0;
        end else if (stall_mode) begin
            fetch_ready_i <= rnd[0];
        end else begin
            fetch_ready_i <= 1'b1;
        end
        fetch_data_i <= mem_word(fetch_addr_o);
    end

    always @(posedge mem2wb_inst_selfdefine_o) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_LIMIT) begin
            $display("Timeout after %0d cycles, %0d expected commits never arrived",
                     cycle_cnt, exp_q.size());
            $display("tests done, %0d errors", err_cnt + 1);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        prog_len = 0;
        boot_after_reset();
        imm_and_lui();
        dependent_alu_ops();
        fetch_backpressure();
        x0_and_illegal();
        $display("tests done, %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top import rv_core_pkg::*; #(
    parameter word_t BOOT_ADDR = 32'h0000_1000
) (
    input  wire logic  mem2wb_inst_selfdefine_o,
    input  wire logic  reset,

    output logic       fetch_valid_o,
    output word_t      fetch_addr_o,
    input  wire logic  fetch_ready_i,
    input  wire word_t fetch_data_i,

    output logic       commit_valid_o,
    output word_t      commit_pc_o,
    output reg_idx_t   commit_rd_o,
    output word_t      commit_data_o
);

    // fetch to decode
    word_t    if_instr;
    word_t    if_pc;
    logic     if_instr_valid;

    // decode and register file
    reg_idx_t id_rs1_idx;
    reg_idx_t id_rs2_idx;
    word_t    rf_rs1_data;
    word_t    rf_rs2_data;

    // decode to execute
    word_t    id_op_a;
    word_t    id_op_b;
    alu_op_e  id_alu_op;
    reg_idx_t id_rd;
    logic     id_rd_we;
    word_t    id_pc;
    logic     id_valid;

    // execute forwarding
    logic     ex_valid;
    reg_idx_t ex_rd;
    word_t    ex_result;

    fetch_unit #(
        .BOOT_ADDR(BOOT_ADDR)
    ) u_fetch (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset                   (reset),
        .fetch_ready_i           (fetch_ready_i),
        .fetch_data_i            (fetch_data_i),
        .fetch_valid_o           (fetch_valid_o),
        .fetch_addr_o            (fetch_addr_o),
        .instr_o                 (if_instr),
        .pc_o                    (if_pc),
        .instr_valid_o           (if_instr_valid)
    );

    decode_unit u_decode (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset                   (reset),
        .instr_i                 (if_instr),
        .pc_i                    (if_pc),
        .instr_valid_i           (if_instr_valid),
        .rs1_idx_o               (id_rs1_idx),
        .rs2_idx_o               (id_rs2_idx),
        .rs1_data_i              (rf_rs1_data),
        .rs2_data_i              (rf_rs2_data),
        .ex_valid_i              (ex_valid),
        .ex_rd_i                 (ex_rd),
        .ex_result_i             (ex_result),
        .op_a_o                  (id_op_a),
        .op_b_o                  (id_op_b),
        .alu_op_o                (id_alu_op),
        .rd_o                    (id_rd),
        .rd_we_o                 (id_rd_we),
        .pc_o                    (id_pc),
        .valid_o                 (id_valid)
    );

    // written from the writeback register
    reg_file u_regs (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset                   (reset),
        .rs1_idx_i               (id_rs1_idx),
        .rs2_idx_i               (id_rs2_idx),
        .rs1_data_o              (rf_rs1_data),
        .rs2_data_o              (rf_rs2_data),
        .wr_en_i                 (commit_valid_o),
        .wr_idx_i                (commit_rd_o),
        .wr_data_i               (commit_data_o)
    );

    exec_unit u_exec (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset                   (reset),
        .op_a_i                  (id_op_a),
        .op_b_i                  (id_op_b),
        .alu_op_i                (id_alu_op),
        .rd_i                    (id_rd),
        .rd_we_i                 (id_rd_we),
        .pc_i                    (id_pc),
        .valid_i                 (id_valid),
        .ex_valid_o              (ex_valid),
        .ex_rd_o                 (ex_rd),
        .ex_result_o             (ex_result),
        .commit_valid_o          (commit_valid_o),
        .commit_pc_o             (commit_pc_o),
        .commit_rd_o             (commit_rd_o),
        .commit_data_o           (commit_data_o)
    );

endmodule

`default_nettype wire

//--- hdl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import rv_core_pkg::*; (
    input  wire logic     mem2wb_inst_selfdefine_o,
    input  wire logic     reset,

    input  wire word_t    instr_i,
    input  wire word_t    pc_i,
    input  wire logic     instr_valid_i,

    output reg_idx_t      rs1_idx_o,
    output reg_idx_t      rs2_idx_o,
    input  wire word_t    rs1_data_i,
    input  wire word_t    rs2_data_i,

    input  wire logic     ex_valid_i,
    input  wire reg_idx_t ex_rd_i,
    input  wire word_t    ex_result_i,

    output word_t         op_a_o,
    output word_t         op_b_o,
    output alu_op_e       alu_op_o,
    output reg_idx_t      rd_o,
    output logic          rd_we_o,
    output word_t         pc_o,
    output logic          valid_o
);

    opcode_e  opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t rd;
    word_t    i_imm;
    word_t    u_imm;
    word_t    imm;
    word_t    rs1_val;
    word_t    rs2_val;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     supported;

    assign opcode    = opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7    = instr_i[31:25];
    assign rd        = instr_i[11:7];
    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];

    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign u_imm = {instr_i[31:12], 12'b0};

    // execute result wins, writeback comes through the register file
    assign rs1_val = (ex_valid_i && (ex_rd_i == rs1_idx_o)) ? ex_result_i : rs1_data_i;
    assign rs2_val = (ex_valid_i && (ex_rd_i == rs2_idx_o)) ? ex_result_i : rs2_data_i;

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        imm       = i_imm;
        supported = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                use_imm   = 1'b1;
                supported = 1'b1;
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    3'b001: begin
                        alu_op    = ALU_SLL;
                        supported = (funct7 == 7'b0000000);
                    end
                    3'b101: begin
                        // srai not supported
                        alu_op    = ALU_SRL;
                        supported = (funct7 == 7'b0000000);
                    end
                    default: supported = 1'b0;
                endcase
            end
            OPC_OP: begin
                supported = (funct7 == 7'b0000000);
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0100000) begin
                            alu_op    = ALU_SUB;
                            supported = 1'b1;
                        end else begin
                            alu_op = ALU_ADD;
                        end
                    end
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: alu_op = ALU_SRL;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OPC_LUI: begin
                alu_op    = ALU_PASS_B;
                use_imm   = 1'b1;
                imm       = u_imm;
                supported = 1'b1;
            end
            default: supported = 1'b0;
        endcase
    end

    // decode/execute register
    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            valid_o  <= 1'b0;
            op_a_o   <= '0;
            op_b_o   <= '0;
            alu_op_o <= ALU_ADD;
            rd_o     <= '0;
            rd_we_o  <= 1'b0;
            pc_o     <= '0;
        end else begin
            valid_o  <= instr_valid_i & supported;
            op_a_o   <= rs1_val;
            op_b_o   <= use_imm ? imm : rs2_val;
            alu_op_o <= alu_op;
            rd_o     <= rd;
            rd_we_o  <= (rd != '0);
            pc_o     <= pc_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_core_pkg::*; (
    input  wire logic     mem2wb_inst_selfdefine_o,
    input  wire logic     reset,

    input  wire word_t    op_a_i,
    input  wire word_t    op_b_i,
    input  wire alu_op_e  alu_op_i,
    input  wire reg_idx_t rd_i,
    input  wire logic     rd_we_i,
    input  wire word_t    pc_i,
    input  wire logic     valid_i,

    output logic          ex_valid_o,
    output reg_idx_t      ex_rd_o,
    output word_t         ex_result_o,

    output logic          commit_valid_o,
    output word_t         commit_pc_o,
    output reg_idx_t      commit_rd_o,
    output word_t         commit_data_o
);

    word_t result;
    logic  lt;

    assign lt = $signed(op_a_i) < $signed(op_b_i);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result = op_a_i + op_b_i;
            ALU_SUB:    result = op_a_i - op_b_i;
            ALU_AND:    result = op_a_i & op_b_i;
            ALU_OR:     result = op_a_i | op_b_i;
            ALU_XOR:    result = op_a_i ^ op_b_i;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt};
            ALU_SLL:    result = op_a_i << op_b_i[4:0];
            ALU_SRL:    result = op_a_i >> op_b_i[4:0];
            ALU_PASS_B: result = op_b_i;
            default:    result = '0;
        endcase
    end

    // forwarding path back to decode, x0 never forwards
    assign ex_valid_o  = valid_i & rd_we_i;
    assign ex_rd_o     = rd_i;
    assign ex_result_o = result;

    // writeback register, also the commit record
    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            commit_valid_o <= 1'b0;
            commit_pc_o    <= '0;
            commit_rd_o    <= '0;
            commit_data_o  <= '0;
        end else begin
            commit_valid_o <= valid_i;
            commit_pc_o    <= pc_i;
            commit_rd_o    <= rd_i;
            commit_data_o  <= result;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_core_pkg::*; #(
    parameter word_t BOOT_ADDR = 32'h0000_1000
) (
    input  wire logic mem2wb_inst_selfdefine_o,
    input  wire logic reset,

    input  wire logic  fetch_ready_i,
    input  wire word_t fetch_data_i,
    output logic       fetch_valid_o,
    output word_t      fetch_addr_o,

    output word_t      instr_o,
    output word_t      pc_o,
    output logic       instr_valid_o
);

    word_t pc_q;
    word_t instr_q;
    word_t instr_pc_q;
    logic  instr_valid_q;
    logic  xfer;

    // no branches, so the request never drops
    assign fetch_valid_o = 1'b1;
    assign fetch_addr_o  = pc_q;
    assign xfer          = fetch_valid_o & fetch_ready_i;

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            pc_q <= BOOT_ADDR;
        end else if (xfer) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // fetch/decode register
    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            instr_valid_q <= 1'b0;
            instr_q       <= '0;
            instr_pc_q    <= '0;
        end else begin
            instr_valid_q <= xfer;
            instr_pc_q    <= pc_q;
            // back-pressure inserts a bubble
            instr_q       <= xfer ? fetch_data_i : NOP_INSTR;
        end
    end

    assign instr_o       = instr_q;
    assign pc_o          = instr_pc_q;
    assign instr_valid_o = instr_valid_q;

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
    input  wire logic     mem2wb_inst_selfdefine_o,
    input  wire logic     reset,

    input  wire reg_idx_t rs1_idx_i,
    input  wire reg_idx_t rs2_idx_i,
    output word_t         rs1_data_o,
    output word_t         rs2_data_o,

    input  wire logic     wr_en_i,
    input  wire reg_idx_t wr_idx_i,
    input  wire word_t    wr_data_i
);

    word_t regs [1:31];

    // x0 reads zero, same-cycle write is bypassed
    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wr_en_i && (wr_idx_i == idx)) begin
            val = wr_data_i;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != '0)) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_idx_i);
        rs2_data_o = read_port(rs2_idx_i);
    end

endmodule

`default_nettype wire

//--- hdl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // major opcodes handled by decode
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        // lui result is the immediate itself
        ALU_PASS_B = 4'd8
    } alu_op_e;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

//--- vlog.f
+incdir+dv
hdl/rv_core_pkg.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/decode_unit.sv
hdl/exec_unit.sv
hdl/core_top.sv
dv/tb_core.sv
